/* files.f */
+incdir+hw
hw/xheep_bus_pkg.sv
hw/xheep_map_pkg.sv
hw/obi_if.sv
hw/apb_obi_bridge.sv
hw/obi_window_decoder.sv
hw/soc_ctrl_regs.sv
hw/obi_axi_master.sv
hw/xheep_esp_wrapper.sv
verif/tb_xheep_wrapper.sv

/* verif/tb_xheep_wrapper.sv */
// Table-driven testbench for the ESP to X-HEEP bridge with an AXI memory responder
`timescale 1ns/1ns
`default_nettype none

`include "xheep_cfg.svh"

module tb_xheep_wrapper
  import xheep_bus_pkg::*;
  import xheep_map_pkg::*;
();

  localparam int NUM_TESTS      = 17;
  localparam int TIMEOUT_CYCLES = 16 + NUM_TESTS * 40;

  typedef struct packed {
    logic      is_write;
    xh_addr_t  paddr;
    xh_data_t  wdata;
    axi_resp_e resp;
    xh_data_t  exp_rdata;
    logic      exp_err;
    logic      exp_intr;
  } entry_t;

  logic      clk;
  logic      rst;
  xh_addr_t  paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  xh_data_t  pwdata;
  xh_data_t  prdata;
  logic      pready;
  logic      pslverr;
  logic      awvalid;
  logic      awready = 1'b0;
  xh_addr_t  awaddr;
  logic      wvalid;
  logic      wready = 1'b0;
  xh_data_t  wdata;
  logic      bvalid = 1'b0;
  logic      bready;
  axi_resp_e bresp = AXI_OKAY;
  logic      arvalid;
  logic      arready = 1'b0;
  xh_addr_t  araddr;
  logic      rvalid = 1'b0;
  logic      rready;
  xh_data_t  rdata = '0;
  axi_resp_e rresp = AXI_OKAY;
  logic      intr;

  integer    seed = 32'hbb6247d0;
  int        err_count = 0;
  int        cycle_count = 0;
  int        n_loaded = 0;
  entry_t    tbl [NUM_TESTS];
  axi_resp_e cur_resp = AXI_OKAY;

  // AXI memory model and the channel logs
  xh_data_t  mem [0:63];
  xh_addr_t  aw_log [$];
  xh_data_t  w_log [$];
  xh_addr_t  ar_log [$];

  xheep_esp_wrapper dut (
    .x_heep_clk_i (clk),
    .reset_i      (rst),
    .paddr_i      (paddr),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .awvalid_o    (awvalid),
    .awready_i    (awready),
    .awaddr_o     (awaddr),
    .wvalid_o     (wvalid),
    .wready_i     (wready),
    .wdata_o      (wdata),
    .bvalid_i     (bvalid),
    .bready_o     (bready),
    .bresp_i      (bresp),
    .arvalid_o    (arvalid),
    .arready_i    (arready),
    .araddr_o     (araddr),
    .rvalid_i     (rvalid),
    .rready_o     (rready),
    .rdata_i      (rdata),
    .rresp_i      (rresp),
    .x_heep_intr_o(intr)
  );

  always begin
    #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // AW ready after 0 to 3 cycles
  always begin : aw_responder
    int dly;
    @(negedge clk);
    if (awvalid) begin
      aw_log.push_back(awaddr);
      dly = $random(seed) & 3;
      repeat (dly) @(posedge clk);
      @(posedge clk);
      #2;
      awready = 1'b1;
      @(posedge clk);
      #2;
      awready = 1'b0;
    end
  end

  always begin : w_responder
    int dly;
    @(negedge clk);
    if (wvalid) begin
      w_log.push_back(wdata);
      dly = $random(seed) & 3;
      repeat (dly) @(posedge clk);
      @(posedge clk);
      #2;
      wready = 1'b1;
      @(posedge clk);
      #2;
      wready = 1'b0;
    end
  end

  // Memory is only updated by writes that complete with OKAY
  always begin : b_responder
    int       dly;
    xh_addr_t a;
    @(negedge clk);
    if (bready) begin
      a = aw_log[$];
      if (cur_resp == AXI_OKAY) mem[a[7:2]] = w_log[$];
      dly = $random(seed) & 3;
      repeat (dly) @(posedge clk);
      @(posedge clk);
      #2;
      bvalid = 1'b1;
      bresp  = cur_resp;
      @(posedge clk);
      #2;
      bvalid = 1'b0;
      bresp  = AXI_OKAY;
    end
  end

  always begin : ar_responder
    int dly;
    @(negedge clk);
    if (arvalid) begin
      ar_log.push_back(araddr);
      dly = $random(seed) & 3;
      repeat (dly) @(posedge clk);
      @(posedge clk);
      #2;
      arready = 1'b1;
      @(posedge clk);
      #2;
      arready = 1'b0;
    end
  end

  always begin : r_responder
    int       dly;
    xh_addr_t a;
    @(negedge clk);
    if (rready) begin
      a = ar_log[$];
      dly = $random(seed) & 3;
      repeat (dly) @(posedge clk);
      @(posedge clk);
      #2;
      rvalid = 1'b1;
      rdata  = mem[a[7:2]];
      rresp  = cur_resp;
      @(posedge clk);
      #2;
      rvalid = 1'b0;
      rresp  = AXI_OKAY;
    end
  end

  task automatic check_addr(input string what, input xh_addr_t got, input xh_addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_data(input string what, input xh_data_t got, input xh_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_resp(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %0t ns: saw %0d %s transfers, expected %0d", $time, got, what, exp);
      err_count++;
    end
  endtask

  task automatic add_entry(input logic is_write, input xh_addr_t addr, input xh_data_t data,
                           input axi_resp_e resp, input xh_data_t exp_rdata,
                           input logic exp_err, input logic exp_intr);
    tbl[n_loaded].is_write  = is_write;
    tbl[n_loaded].paddr     = addr;
    tbl[n_loaded].wdata     = data;
    tbl[n_loaded].resp      = resp;
    tbl[n_loaded].exp_rdata = exp_rdata;
    tbl[n_loaded].exp_err   = exp_err;
    tbl[n_loaded].exp_intr  = exp_intr;
    n_loaded++;
  endtask

  // Offsets below the SoC control offset leave on AXI
  function automatic logic in_ram_window(input xh_addr_t addr);
    return xh_addr_t'(addr[`XH_OFFSET_W-1:0]) < `XH_SOC_CTRL_WRITE_OFFSET;
  endfunction

  function automatic xh_addr_t esp_addr(input xh_addr_t addr);
    return `XH_ESP_MEM_START + xh_addr_t'(addr[`XH_OFFSET_W-1:0]);
  endfunction

  // APB offset of a SoC control register word
  function automatic xh_addr_t ctrl_offset(input soc_reg_e idx);
    return `XH_SOC_CTRL_WRITE_OFFSET + (xh_addr_t'(idx) << 2);
  endfunction

  // One APB access with the response sampled mid-cycle while pready is high
  task automatic apb_access(input logic is_write, input xh_addr_t addr, input xh_data_t data,
                            output xh_data_t rd, output logic err, output logic irq);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwrite  = is_write;
    pwdata  = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);
    rd  = prdata;
    err = pslverr;
    irq = intr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial begin
    int       errs_before;
    int       aw_n;
    int       w_n;
    int       ar_n;
    xh_data_t got_rdata;
    logic     got_err;
    logic     got_intr;

    clk     = 1'b0;
    rst     = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    for (int k = 0; k < 64; k++) mem[k] = 32'hC0DE_0000 + k * 32'h0000_0101;

    // RAM window with ESP routing bits set above the offset
    add_entry(1'b1, 32'h0A30_0010, 32'h1234_5678, AXI_OKAY, '0, 1'b0, 1'b0);
    add_entry(1'b0, 32'h0A30_0010, '0, AXI_OKAY, 32'h1234_5678, 1'b0, 1'b0);
    add_entry(1'b0, 32'h0000_0020, '0, AXI_OKAY, 32'hC0DE_0808, 1'b0, 1'b0);
    add_entry(1'b0, 32'h0000_00F0, '0, AXI_EXOKAY, 32'hC0DE_3C3C, 1'b0, 1'b0);
    // SoC control registers
    add_entry(1'b1, ctrl_offset(REG_SCRATCH), 32'hDEAD_BEEF, AXI_OKAY, '0, 1'b0, 1'b0);
    add_entry(1'b0, ctrl_offset(REG_SCRATCH), '0, AXI_OKAY, 32'hDEAD_BEEF, 1'b0, 1'b0);
    add_entry(1'b1, ctrl_offset(REG_EXIT_VALUE), 32'h0000_00A5, AXI_OKAY, '0, 1'b0, 1'b0);
    add_entry(1'b0, ctrl_offset(REG_EXIT_VALUE), '0, AXI_OKAY, 32'h0000_00A5, 1'b0, 1'b0);
    add_entry(1'b1, ctrl_offset(REG_EXIT_VALID), 32'h0000_0001, AXI_OKAY, '0, 1'b0, 1'b1);
    add_entry(1'b0, ctrl_offset(REG_EXIT_VALID), '0, AXI_OKAY, 32'h0000_0001, 1'b0, 1'b1);
    add_entry(1'b1, ctrl_offset(REG_EXIT_VALID), 32'h0000_0000, AXI_OKAY, '0, 1'b0, 1'b0);
    add_entry(1'b0, ctrl_offset(REG_EXIT_VALID), '0, AXI_OKAY, 32'h0000_0000, 1'b0, 1'b0);
    // Error paths
    add_entry(1'b1, 32'h0000_0040, 32'h5555_AAAA, AXI_SLVERR, '0, 1'b1, 1'b0);
    add_entry(1'b0, 32'h0000_0044, '0, AXI_SLVERR, '0, 1'b1, 1'b0);
    add_entry(1'b0, 32'h0000_0080, '0, AXI_DECERR, '0, 1'b1, 1'b0);
    add_entry(1'b0, 32'h0000_FF0C, '0, AXI_OKAY, '0, 1'b1, 1'b0);
    add_entry(1'b1, 32'h0000_FF10, 32'h0000_0001, AXI_OKAY, '0, 1'b1, 1'b0);

    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_resp("pready after reset", pready, 1'b0);
    check_resp("pslverr after reset", pslverr, 1'b0);
    check_resp("awvalid after reset", awvalid, 1'b0);
    check_resp("wvalid after reset", wvalid, 1'b0);
    check_resp("arvalid after reset", arvalid, 1'b0);
    check_resp("bready after reset", bready, 1'b0);
    check_resp("rready after reset", rready, 1'b0);
    check_resp("interrupt after reset", intr, 1'b0);
    $display("Test 0 (reset): %s", (err_count == 0) ? "ok" : "mismatch");

    for (int i = 0; i < NUM_TESTS; i++) begin
      errs_before = err_count;
      aw_n = aw_log.size();
      w_n  = w_log.size();
      ar_n = ar_log.size();
      cur_resp = tbl[i].resp;
      apb_access(tbl[i].is_write, tbl[i].paddr, tbl[i].wdata, got_rdata, got_err, got_intr);
      check_resp("pslverr", got_err, tbl[i].exp_err);
      check_resp("interrupt", got_intr, tbl[i].exp_intr);
      if (!tbl[i].is_write && !tbl[i].exp_err) begin
        check_data("prdata", got_rdata, tbl[i].exp_rdata);
      end
      if (!in_ram_window(tbl[i].paddr)) begin
        check_count("AW", aw_log.size() - aw_n, 0);
        check_count("W", w_log.size() - w_n, 0);
        check_count("AR", ar_log.size() - ar_n, 0);
      end else if (tbl[i].is_write) begin
        check_count("AW", aw_log.size() - aw_n, 1);
        check_count("W", w_log.size() - w_n, 1);
        check_count("AR", ar_log.size() - ar_n, 0);
        if (aw_log.size() > aw_n) check_addr("awaddr", aw_log[$], esp_addr(tbl[i].paddr));
        if (w_log.size() > w_n) check_data("wdata", w_log[$], tbl[i].wdata);
      end else begin
        check_count("AW", aw_log.size() - aw_n, 0);
        check_count("W", w_log.size() - w_n, 0);
        check_count("AR", ar_log.size() - ar_n, 1);
        if (ar_log.size() > ar_n) check_addr("araddr", ar_log[$], esp_addr(tbl[i].paddr));
      end
      $display("Test %0d (%s %h): %s", i + 1, tbl[i].is_write ? "write" : "read",
               tbl[i].paddr, (err_count == errs_before) ? "ok" : "mismatch");
    end

    $display("Tests run: %0d, failed checks: %0d", NUM_TESTS + 1, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/xheep_esp_wrapper.sv */
// ESP to X-HEEP bridge top with APB slave, AXI4 master and exit interrupt
`timescale 1ns/1ns
`default_nettype none

module xheep_esp_wrapper (
  input  logic                     x_heep_clk_i,
  input  logic                     reset_i,
  // APB slave
  input  xheep_bus_pkg::xh_addr_t  paddr_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  xheep_bus_pkg::xh_data_t  pwdata_i,
  output xheep_bus_pkg::xh_data_t  prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // AXI4 master
  output logic                     awvalid_o,
  input  logic                     awready_i,
  output xheep_bus_pkg::xh_addr_t  awaddr_o,
  output logic                     wvalid_o,
  input  logic                     wready_i,
  output xheep_bus_pkg::xh_data_t  wdata_o,
  input  logic                     bvalid_i,
  output logic                     bready_o,
  input  xheep_bus_pkg::axi_resp_e bresp_i,
  output logic                     arvalid_o,
  input  logic                     arready_i,
  output xheep_bus_pkg::xh_addr_t  araddr_o,
  input  logic                     rvalid_i,
  output logic                     rready_o,
  input  xheep_bus_pkg::xh_data_t  rdata_i,
  input  xheep_bus_pkg::axi_resp_e rresp_i,
  // Interrupt to ESP
  output logic                     x_heep_intr_o
);

  obi_if bridge_obi ();
  obi_if ctrl_obi ();
  obi_if ext_obi ();

  apb_obi_bridge u_apb_obi_bridge (
    .x_heep_clk_i (x_heep_clk_i),
    .reset_i      (reset_i),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .obi          (bridge_obi.manager)
  );

  obi_window_decoder u_obi_window_decoder (
    .x_heep_clk_i (x_heep_clk_i),
    .reset_i      (reset_i),
    .up           (bridge_obi.subordinate),
    .ctrl         (ctrl_obi.manager),
    .ext          (ext_obi.manager)
  );

  soc_ctrl_regs u_soc_ctrl_regs (
    .x_heep_clk_i  (x_heep_clk_i),
    .reset_i       (reset_i),
    .obi           (ctrl_obi.subordinate),
    .x_heep_intr_o (x_heep_intr_o)
  );

  obi_axi_master u_obi_axi_master (
    .x_heep_clk_i (x_heep_clk_i),
    .reset_i      (reset_i),
    .obi          (ext_obi.subordinate),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .awaddr_o     (awaddr_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .wdata_o      (wdata_o),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o),
    .bresp_i      (bresp_i),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .araddr_o     (araddr_o),
    .rvalid_i     (rvalid_i),
    .rready_o     (rready_o),
    .rdata_i      (rdata_i),
    .rresp_i      (rresp_i)
  );

endmodule

`default_nettype wire

/* hw/obi_axi_master.sv */
// OBI subordinate issuing single-beat AXI4 transfers rebased into ESP memory
`timescale 1ns/1ns
`default_nettype none

`include "xheep_cfg.svh"

module obi_axi_master
  import xheep_bus_pkg::*;
(
  input  logic       x_heep_clk_i,
  input  logic       reset_i,
  obi_if.subordinate obi,
  // AW
  output logic       awvalid_o,
  input  logic       awready_i,
  output xh_addr_t   awaddr_o,
  // W
  output logic       wvalid_o,
  input  logic       wready_i,
  output xh_data_t   wdata_o,
  // B
  input  logic       bvalid_i,
  output logic       bready_o,
  input  axi_resp_e  bresp_i,
  // AR
  output logic       arvalid_o,
  input  logic       arready_i,
  output xh_addr_t   araddr_o,
  // R
  input  logic       rvalid_i,
  output logic       rready_o,
  input  xh_data_t   rdata_i,
  input  axi_resp_e  rresp_i
);

  typedef enum logic [2:0] {
    IDLE,
    WRITE_ADDR_DATA,
    WRITE_RESP,
    READ_ADDR,
    READ_DATA,
    REPLY
  } state_e;

  state_e   state_q, state_d;
  logic     accept;
  logic     aw_hs, w_hs;
  logic     aw_done_q, w_done_q;
  xh_addr_t addr_q;
  xh_data_t wdata_q;
  xh_data_t rdata_q;
  logic     err_q;

  // SLVERR and DECERR both report as OBI err
  function automatic logic is_error(axi_resp_e resp);
    return !(resp inside {AXI_OKAY, AXI_EXOKAY});
  endfunction

  assign accept     = obi.req && (state_q == IDLE);
  assign obi.gnt    = accept;
  assign obi.rvalid = (state_q == REPLY);
  assign obi.rdata  = rdata_q;
  assign obi.err    = err_q;

  // AW and W go out together, each drops once accepted
  assign awvalid_o = (state_q == WRITE_ADDR_DATA) && !aw_done_q;
  assign wvalid_o  = (state_q == WRITE_ADDR_DATA) && !w_done_q;
  assign aw_hs     = awvalid_o && awready_i;
  assign w_hs      = wvalid_o && wready_i;
  assign bready_o  = (state_q == WRITE_RESP);
  assign arvalid_o = (state_q == READ_ADDR);
  assign rready_o  = (state_q == READ_DATA);

  assign awaddr_o = addr_q;
  assign araddr_o = addr_q;
  assign wdata_o  = wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) state_d = obi.we ? WRITE_ADDR_DATA : READ_ADDR;
      end
      WRITE_ADDR_DATA: begin
        if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) state_d = WRITE_RESP;
      end
      WRITE_RESP: begin
        if (bvalid_i) state_d = REPLY;
      end
      READ_ADDR: begin
        if (arready_i) state_d = READ_DATA;
      end
      READ_DATA: begin
        if (rvalid_i) state_d = REPLY;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge x_heep_clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != WRITE_ADDR_DATA) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        if (aw_hs) aw_done_q <= 1'b1;
        if (w_hs) w_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge x_heep_clk_i) begin
    if (accept) begin
      // External slave window maps onto ESP memory
      addr_q  <= obi.addr - `XH_EXT_SLAVE_START + `XH_ESP_MEM_START;
      wdata_q <= obi.wdata;
    end
    if (bready_o && bvalid_i) begin
      rdata_q <= '0;
      err_q   <= is_error(bresp_i);
    end
    if (rready_o && rvalid_i) begin
      rdata_q <= rdata_i;
      err_q   <= is_error(rresp_i);
    end
  end

endmodule

`default_nettype wire

/* hw/soc_ctrl_regs.sv */
// SoC control register block with scratch, exit value and exit interrupt
`timescale 1ns/1ns
`default_nettype none

`include "xheep_cfg.svh"

module soc_ctrl_regs
  import xheep_bus_pkg::*;
  import xheep_map_pkg::*;
(
  input  logic       x_heep_clk_i,
  input  logic       reset_i,
  obi_if.subordinate obi,
  output logic       x_heep_intr_o
);

  xh_addr_t rel_addr;
  soc_reg_e reg_idx;
  logic     in_range;
  logic     wr_en;
  xh_data_t rd_value;

  xh_data_t scratch_q;
  xh_data_t exit_value_q;
  logic     exit_valid_q;
  logic     rvalid_q;
  xh_data_t rdata_q;
  logic     err_q;

  // Word index relative to the block base
  assign rel_addr = obi.addr - `XH_SOC_CTRL_START;
  assign reg_idx  = soc_reg_e'(rel_addr[3:2]);
  assign in_range = rel_addr[`XH_ADDR_W-1:2] < `XH_SOC_CTRL_REGS;
  assign wr_en    = obi.req && obi.we && in_range;

  assign obi.gnt    = obi.req;
  assign obi.rvalid = rvalid_q;
  assign obi.rdata  = rdata_q;
  assign obi.err    = err_q;

  assign x_heep_intr_o = exit_valid_q;

  always_comb begin
    case (reg_idx)
      REG_SCRATCH:    rd_value = scratch_q;
      REG_EXIT_VALUE: rd_value = exit_value_q;
      REG_EXIT_VALID: rd_value = {{(`XH_DATA_W-1){1'b0}}, exit_valid_q};
      default:        rd_value = '0;
    endcase
  end

  always_ff @(posedge x_heep_clk_i) begin
    if (reset_i) begin
      scratch_q    <= '0;
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= obi.req;
      if (wr_en) begin
        case (reg_idx)
          REG_SCRATCH:    scratch_q    <= obi.wdata;
          REG_EXIT_VALUE: exit_value_q <= obi.wdata;
          REG_EXIT_VALID: exit_valid_q <= obi.wdata[0];
          default:        scratch_q    <= scratch_q;
        endcase
      end
    end
  end

  // Reads see the value from before a same-cycle write
  always_ff @(posedge x_heep_clk_i) begin
    if (obi.req) begin
      rdata_q <= in_range ? rd_value : '0;
      err_q   <= !in_range;
    end
  end

endmodule

`default_nettype wire

/* hw/obi_window_decoder.sv */
// Maps the APB offset into the X-HEEP map and routes OBI to SoC control or external slave
`timescale 1ns/1ns
`default_nettype none

`include "xheep_cfg.svh"

module obi_window_decoder
  import xheep_bus_pkg::*;
  import xheep_map_pkg::*;
(
  input  logic       x_heep_clk_i,
  input  logic       reset_i,
  obi_if.subordinate up,
  obi_if.manager     ctrl,
  obi_if.manager     ext
);

  typedef enum logic {
    TGT_EXT,
    TGT_CTRL
  } target_e;

  xh_offset_t offset;
  xh_addr_t   offset_ext;
  target_e    target;
  target_e    target_q;

  assign offset     = up.addr[`XH_OFFSET_W-1:0];
  assign offset_ext = xh_addr_t'(offset);
  assign target     = (offset_ext >= `XH_SOC_CTRL_WRITE_OFFSET) ? TGT_CTRL : TGT_EXT;

  // SoC control window starts at the write offset
  assign ctrl.req   = up.req && (target == TGT_CTRL);
  assign ctrl.addr  = `XH_SOC_CTRL_START + (offset_ext - `XH_SOC_CTRL_WRITE_OFFSET);
  assign ctrl.we    = up.we;
  assign ctrl.wdata = up.wdata;

  // Everything lower is RAM window traffic for the external slave port
  assign ext.req    = up.req && (target == TGT_EXT);
  assign ext.addr   = `XH_EXT_SLAVE_START + offset_ext;
  assign ext.we     = up.we;
  assign ext.wdata  = up.wdata;

  assign up.gnt = (target == TGT_CTRL) ? ctrl.gnt : ext.gnt;

  // Response follows the target that granted, not the current address
  assign up.rvalid = (target_q == TGT_CTRL) ? ctrl.rvalid : ext.rvalid;
  assign up.rdata  = (target_q == TGT_CTRL) ? ctrl.rdata  : ext.rdata;
  assign up.err    = (target_q == TGT_CTRL) ? ctrl.err    : ext.err;

  always_ff @(posedge x_heep_clk_i) begin
    if (reset_i) begin
      target_q <= TGT_EXT;
    end else if (up.req && up.gnt) begin
      target_q <= target;
    end
  end

endmodule

`default_nettype wire

/* hw/apb_obi_bridge.sv */
// APB slave that turns each APB access into a single OBI transaction
`timescale 1ns/1ns
`default_nettype none

`include "xheep_cfg.svh"

module apb_obi_bridge
  import xheep_bus_pkg::*;
  import xheep_map_pkg::*;
(
  input  logic     x_heep_clk_i,
  input  logic     reset_i,
  input  xh_addr_t paddr_i,
  input  logic     psel_i,
  input  logic     penable_i,
  input  logic     pwrite_i,
  input  xh_data_t pwdata_i,
  output xh_data_t prdata_o,
  output logic     pready_o,
  output logic     pslverr_o,
  obi_if.manager   obi
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    RESPONSE,
    DONE
  } state_e;

  state_e     state_q, state_d;
  xh_offset_t offset;
  xh_data_t   rdata_q;
  logic       err_q;

  // ESP routing bits sit above the offset and are dropped here
  assign offset = paddr_i[`XH_OFFSET_W-1:0];

  // APB keeps address and data stable until pready, so they feed OBI directly
  assign obi.req   = (state_q == REQUEST);
  assign obi.addr  = {{(`XH_ADDR_W-`XH_OFFSET_W){1'b0}}, offset};
  assign obi.we    = pwrite_i;
  assign obi.wdata = pwdata_i;

  assign pready_o  = (state_q == DONE);
  assign pslverr_o = (state_q == DONE) && err_q;
  assign prdata_o  = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (psel_i && penable_i) state_d = REQUEST;
      end
      REQUEST: begin
        if (obi.gnt) state_d = RESPONSE;
      end
      RESPONSE: begin
        if (obi.rvalid) state_d = DONE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge x_heep_clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response is held until the APB access completes
  always_ff @(posedge x_heep_clk_i) begin
    if (state_q == RESPONSE && obi.rvalid) begin
      rdata_q <= obi.rdata;
      err_q   <= obi.err;
    end
  end

endmodule

`default_nettype wire

/* hw/obi_if.sv */
// OBI link carrying one request channel and one response channel
`timescale 1ns/1ns
`default_nettype none

interface obi_if
  import xheep_bus_pkg::*;
();

  // Manager to subordinate
  logic     req;
  xh_addr_t addr;
  logic     we;
  xh_data_t wdata;

  // Subordinate to manager
  logic     gnt;
  logic     rvalid;
  xh_data_t rdata;
  logic     err;

  modport manager (
    output req, addr, we, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport subordinate (
    input  req, addr, we, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

/* hw/xheep_map_pkg.sv */
// Address map types for the APB offset and the SoC control registers
`default_nettype none

`include "xheep_cfg.svh"

package xheep_map_pkg;

  // Offset within the window ESP allocates to X-HEEP
  typedef logic [`XH_OFFSET_W-1:0] xh_offset_t;

  // Word index inside the SoC control block
  typedef enum logic [1:0] {
    REG_SCRATCH    = 2'd0,
    REG_EXIT_VALUE = 2'd1,
    REG_EXIT_VALID = 2'd2
  } soc_reg_e;

endpackage

`default_nettype wire

/* hw/xheep_bus_pkg.sv */
// Bus protocol types shared by the OBI links, the bridges and the AXI master
`default_nettype none

`include "xheep_cfg.svh"

package xheep_bus_pkg;

  typedef logic [`XH_ADDR_W-1:0] xh_addr_t;
  typedef logic [`XH_DATA_W-1:0] xh_data_t;

  // AXI4 BRESP / RRESP encodings
  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_EXOKAY = 2'b01,
    AXI_SLVERR = 2'b10,
    AXI_DECERR = 2'b11
  } axi_resp_e;

endpackage

`default_nettype wire

/* hw/xheep_cfg.svh */
// X-HEEP bridge widths and address map constants
`ifndef XHEEP_CFG_SVH
`define XHEEP_CFG_SVH

// Bus widths
`define XH_ADDR_W 32
`define XH_DATA_W 32

// APB offset bits left once the ESP routing bits are stripped
`define XH_OFFSET_W 20

// Offsets at or above this land in SoC control
`define XH_SOC_CTRL_WRITE_OFFSET 32'h0000_FF00

// X-HEEP and ESP memory map bases
`define XH_SOC_CTRL_START  32'h2000_0000
`define XH_EXT_SLAVE_START 32'hF000_0000
`define XH_ESP_MEM_START   32'h8000_0000

`define XH_SOC_CTRL_REGS 3

`endif
